// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_exec_core
RTL_TOP    ?= exec_core
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only -Wall --timescale 1ns/100ps

SOURCES := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter-out tb_%.sv,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
cpu_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
exec_core.sv
tb_exec_core.sv

// File: cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Widths and register indices
	////////////////////////////////////////////////////////////

	localparam int xlen = 16;
	localparam int reg_aw = 4;
	localparam int num_regs = 2 ** reg_aw;
	// Shift amount takes the low bits of rt
	localparam int shamt_w = $clog2(xlen);

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_aw-1:0] reg_addr_t;

	localparam reg_addr_t zero_reg = 4'd0;
	localparam reg_addr_t link_reg = 4'd13;

	// Instruction field positions
	localparam int op_hi = 15;
	localparam int op_lo = 12;
	localparam int rd_hi = 11;
	localparam int rd_lo = 8;
	localparam int rs_hi = 7;
	localparam int rs_lo = 4;
	localparam int rt_hi = 3;
	localparam int rt_lo = 0;

	// Codes 12 to 15 decode as nop as well
	typedef enum logic [3:0] {
		nop    = 4'h0,
		add    = 4'h1,
		sub    = 4'h2,
		and_op = 4'h3,
		or_op  = 4'h4,
		xor_op = 4'h5,
		sll    = 4'h6,
		srl    = 4'h7,
		slt    = 4'h8,
		addi   = 4'h9,
		li     = 4'ha,
		call   = 4'hb
	} opcode_t;

	////////////////////////////////////////////////////////////
	// Stage records
	////////////////////////////////////////////////////////////

	// Decode to execute
	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		word_t     a;
		word_t     b;
		logic      link;
	} ex_op_t;

	// Execute to writeback
	typedef struct packed {
		logic      valid;
		logic      link;
		reg_addr_t rd;
		word_t     value;
	} wb_t;

endpackage

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     read_value1,
	input  cpu_pkg::word_t     read_value2,
	output cpu_pkg::reg_addr_t read_addr1,
	output cpu_pkg::reg_addr_t read_addr2,
	output cpu_pkg::ex_op_t    ex_op
);

	cpu_pkg::opcode_t   op;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::reg_addr_t rs;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::ex_op_t    ex_next;

	// Field split
	assign op = cpu_pkg::opcode_t'(instr[cpu_pkg::op_hi:cpu_pkg::op_lo]);
	assign rd = instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
	assign rs = instr[cpu_pkg::rs_hi:cpu_pkg::rs_lo];
	assign rt = instr[cpu_pkg::rt_hi:cpu_pkg::rt_lo];

	assign read_addr1 = rs;
	assign read_addr2 = rt;

	always_comb begin
		ex_next.valid = instr_valid;
		ex_next.op = op;
		ex_next.rd = rd;
		ex_next.a = read_value1;
		ex_next.b = read_value2;
		ex_next.link = 1'b0;
		case (op)
			cpu_pkg::add, cpu_pkg::sub, cpu_pkg::and_op, cpu_pkg::or_op,
			cpu_pkg::xor_op, cpu_pkg::sll, cpu_pkg::srl, cpu_pkg::slt: begin
				ex_next.b = read_value2;
			end
			cpu_pkg::addi: begin
				ex_next.b = cpu_pkg::word_t'(rt);
			end
			// Immediate spans the rs and rt fields
			cpu_pkg::li: begin
				ex_next.b = cpu_pkg::word_t'(instr[cpu_pkg::rs_hi:cpu_pkg::rt_lo]);
			end
			cpu_pkg::call: begin
				ex_next.link = 1'b1;
				ex_next.rd = cpu_pkg::link_reg;
				ex_next.b = pc + 1'b1;
			end
			cpu_pkg::nop: ex_next.valid = 1'b0;
			default: ex_next.valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		ex_op <= ex_next;
		if (!rst_n) begin
			ex_op.valid <= 1'b0;
		end
	end

	a_instr_known: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> !$isunknown(instr));

endmodule

// File: exec_core.sv
`timescale 1ns/100ps

module exec_core (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           instr_valid,
	input  cpu_pkg::word_t instr,
	input  cpu_pkg::word_t pc,
	output cpu_pkg::wb_t   result,
	output cpu_pkg::word_t debug_out
);

	// Decode to register file
	cpu_pkg::reg_addr_t read_addr1;
	cpu_pkg::reg_addr_t read_addr2;
	cpu_pkg::word_t     read_value1;
	cpu_pkg::word_t     read_value2;

	cpu_pkg::ex_op_t    ex_op;

	// Execute forwarding port
	cpu_pkg::reg_addr_t alu_write_addr;
	cpu_pkg::word_t     alu_write_value;
	logic               alu_writable;

	// Writeback and link ports
	logic               writable;
	cpu_pkg::reg_addr_t write_addr;
	cpu_pkg::word_t     write_value;
	logic               link_writable;
	cpu_pkg::word_t     link_value;

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.read_value1 (read_value1),
		.read_value2 (read_value2),
		.read_addr1  (read_addr1),
		.read_addr2  (read_addr2),
		.ex_op       (ex_op)
	);

	reg_file u_reg_file (
		.clk             (clk),
		.rst_n           (rst_n),
		.writable        (writable),
		.write_addr      (write_addr),
		.write_value     (write_value),
		.alu_writable    (alu_writable),
		.alu_write_addr  (alu_write_addr),
		.alu_write_value (alu_write_value),
		.link_writable   (link_writable),
		.link_value      (link_value),
		.read_addr1      (read_addr1),
		.read_value1     (read_value1),
		.read_addr2      (read_addr2),
		.read_value2     (read_value2),
		.debug_out       (debug_out)
	);

	execute_stage u_execute (
		.clk             (clk),
		.rst_n           (rst_n),
		.ex_op           (ex_op),
		.alu_writable    (alu_writable),
		.alu_write_addr  (alu_write_addr),
		.alu_write_value (alu_write_value),
		.writable        (writable),
		.write_addr      (write_addr),
		.write_value     (write_value),
		.link_writable   (link_writable),
		.link_value      (link_value),
		.result          (result)
	);

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::ex_op_t    ex_op,

	output logic               alu_writable,
	output cpu_pkg::reg_addr_t alu_write_addr,
	output cpu_pkg::word_t     alu_write_value,

	output logic               writable,
	output cpu_pkg::reg_addr_t write_addr,
	output cpu_pkg::word_t     write_value,

	output logic               link_writable,
	output cpu_pkg::word_t     link_value,

	output cpu_pkg::wb_t       result
);

	cpu_pkg::word_t alu_out;
	cpu_pkg::wb_t   wb_next;
	logic           a_lt_b;

	assign a_lt_b = $signed(ex_op.a) < $signed(ex_op.b);

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ex_op.op)
			cpu_pkg::add, cpu_pkg::addi: alu_out = ex_op.a + ex_op.b;
			cpu_pkg::sub:    alu_out = ex_op.a - ex_op.b;
			cpu_pkg::and_op: alu_out = ex_op.a & ex_op.b;
			cpu_pkg::or_op:  alu_out = ex_op.a | ex_op.b;
			cpu_pkg::xor_op: alu_out = ex_op.a ^ ex_op.b;
			cpu_pkg::sll:    alu_out = ex_op.a << ex_op.b[cpu_pkg::shamt_w-1:0];
			cpu_pkg::srl:    alu_out = ex_op.a >> ex_op.b[cpu_pkg::shamt_w-1:0];
			cpu_pkg::slt:    alu_out = {{(cpu_pkg::xlen-1){1'b0}}, a_lt_b};
			// Decoder already placed the immediate or pc + 1 in b
			cpu_pkg::li, cpu_pkg::call: alu_out = ex_op.b;
			default: alu_out = '0;
		endcase
	end

	// Forward only results that will reach the register file.
	// r13 is forwarded for call but never for an ordinary write
	assign alu_writable = ex_op.valid && (ex_op.rd != cpu_pkg::zero_reg)
		&& (ex_op.link || (ex_op.rd != cpu_pkg::link_reg));
	assign alu_write_addr = ex_op.rd;
	assign alu_write_value = alu_out;

	////////////////////////////////////////////////////////////
	// Writeback register
	////////////////////////////////////////////////////////////

	always_comb begin
		wb_next.valid = ex_op.valid;
		wb_next.link = ex_op.link;
		wb_next.rd = ex_op.rd;
		wb_next.value = alu_out;
	end

	always_ff @(posedge clk) begin
		result <= wb_next;
		if (!rst_n) begin
			result.valid <= 1'b0;
		end
	end

	// Normal results go to the write port and call goes to the link port
	assign writable = result.valid && !result.link
		&& (result.rd != cpu_pkg::zero_reg) && (result.rd != cpu_pkg::link_reg);
	assign write_addr = result.rd;
	assign write_value = result.value;

	assign link_writable = result.valid && result.link;
	assign link_value = result.value;

	a_link_rd: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_op.valid && ex_op.link) |-> (ex_op.rd == cpu_pkg::link_reg));

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               writable,
	input  cpu_pkg::reg_addr_t write_addr,
	input  cpu_pkg::word_t     write_value,

	input  logic               alu_writable,
	input  cpu_pkg::reg_addr_t alu_write_addr,
	input  cpu_pkg::word_t     alu_write_value,

	input  logic               link_writable,
	input  cpu_pkg::word_t     link_value,

	input  cpu_pkg::reg_addr_t read_addr1,
	output cpu_pkg::word_t     read_value1,

	input  cpu_pkg::reg_addr_t read_addr2,
	output cpu_pkg::word_t     read_value2,

	output cpu_pkg::word_t     debug_out
);

	cpu_pkg::word_t regs [cpu_pkg::num_regs];

	// Low nibbles of r1 r2 r4 r5 with r1 on top
	assign debug_out = {regs[1][3:0], regs[2][3:0], regs[4][3:0], regs[5][3:0]};

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// r0 stays zero and r13 belongs to the link port
			if (writable && (write_addr != cpu_pkg::zero_reg)
					&& (write_addr != cpu_pkg::link_reg)) begin
				regs[write_addr] <= write_value;
			end
			if (link_writable) begin
				regs[cpu_pkg::link_reg] <= link_value;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports with forwarding
	////////////////////////////////////////////////////////////

	// Newest value first, execute then link then writeback
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		cpu_pkg::word_t value;
		if (addr == cpu_pkg::zero_reg) begin
			value = '0;
		end else if (alu_writable && (alu_write_addr == addr)) begin
			value = alu_write_value;
		end else if (link_writable && (addr == cpu_pkg::link_reg)) begin
			value = link_value;
		end else if (writable && (write_addr == addr)
				&& (addr != cpu_pkg::link_reg)) begin
			value = write_value;   // only forward what will really land
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		read_value1 = read_port(read_addr1);
	end

	always_comb begin
		read_value2 = read_port(read_addr2);
	end

	// Zero register holds across every write and link cycle
	a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
		regs[cpu_pkg::zero_reg] == '0);

	// Writeback drives one port at a time
	a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
		!(writable && link_writable));

endmodule

// File: tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;

	localparam int reset_cycles = 10;
	// Issue and idle cycles over all tests
	// Watchdog allows twice the total
	localparam int issue_budget = 65;
	localparam int idle_budget = 52;
	localparam int watchdog_ns = (reset_cycles + issue_budget + idle_budget) * 8 * 2;

	logic           clk = 1'b0;
	logic           rst_n;
	logic           instr_valid;
	cpu_pkg::word_t instr;
	cpu_pkg::word_t pc;
	cpu_pkg::wb_t   result;
	cpu_pkg::word_t debug_out;

	// Reference register file and expected results in issue order
	cpu_pkg::word_t model [16];
	cpu_pkg::wb_t   exp_q [$];
	int             due_q [$];
	string          name_q [$];
	string          test_name = "none";
	cpu_pkg::word_t next_pc = '0;
	int             cycle = 0;
	int             mismatches = 0;
	int             failures = 0;

	exec_core DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.result      (result),
		.debug_out   (debug_out)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	function automatic string wb_text(input cpu_pkg::wb_t wb);
		return $sformatf("valid=%0b link=%0b rd=%0d value=%h", wb.valid, wb.link, wb.rd,
			wb.value);
	endfunction

	task automatic check_result(input string name, input cpu_pkg::wb_t exp,
			input cpu_pkg::wb_t act);
		if (act !== exp) begin
			$display("ERR %s expected %s actual %s", name, wb_text(exp), wb_text(act));
			mismatches++;
		end
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
			input cpu_pkg::word_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			mismatches++;
		end
	endtask

	// Every valid issue shows up exactly two cycles later
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (due_q.size() > 0 && due_q[0] == cycle) begin
				if (result.valid !== 1'b1) begin
					$display("%s: result missing two cycles after issue", name_q[0]);
					failures++;
				end else begin
					check_result(name_q[0], exp_q[0], result);
				end
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
				void'(name_q.pop_front());
			end else if (result.valid !== 1'b0) begin
				$display("%s: unexpected result at cycle %0d", test_name, cycle);
				failures++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic cpu_pkg::word_t instr_word(input logic [3:0] code,
			input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs,
			input cpu_pkg::reg_addr_t rt);
		return {code, rd, rs, rt};
	endfunction

	// Drives one instruction and predicts its result from the model
	task automatic issue(input cpu_pkg::word_t word);
		logic [3:0]         code;
		cpu_pkg::reg_addr_t rd;
		cpu_pkg::reg_addr_t rs;
		cpu_pkg::reg_addr_t rt;
		cpu_pkg::word_t     a;
		cpu_pkg::word_t     b;
		cpu_pkg::word_t     value;
		logic               link;
		logic               produces;
		cpu_pkg::wb_t       exp;
		code = word[cpu_pkg::op_hi:cpu_pkg::op_lo];
		rd = word[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
		rs = word[cpu_pkg::rs_hi:cpu_pkg::rs_lo];
		rt = word[cpu_pkg::rt_hi:cpu_pkg::rt_lo];
		a = model[rs];
		b = model[rt];
		value = '0;
		link = 1'b0;
		produces = 1'b1;
		case (code)
			cpu_pkg::add:    value = a + b;
			cpu_pkg::sub:    value = a - b;
			cpu_pkg::and_op: value = a & b;
			cpu_pkg::or_op:  value = a | b;
			cpu_pkg::xor_op: value = a ^ b;
			cpu_pkg::sll:    value = a << b[3:0];
			cpu_pkg::srl:    value = a >> b[3:0];
			cpu_pkg::slt:    value = {15'd0, $signed(a) < $signed(b)};
			cpu_pkg::addi:   value = a + {12'd0, rt};
			cpu_pkg::li:     value = {8'd0, rs, rt};
			cpu_pkg::call: begin
				value = next_pc + 16'd1;
				rd = cpu_pkg::link_reg;
				link = 1'b1;
			end
			default: produces = 1'b0;
		endcase
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr = word;
		pc = next_pc;
		next_pc = next_pc + 16'd1;
		if (produces) begin
			exp.valid = 1'b1;
			exp.link = link;
			exp.rd = rd;
			exp.value = value;
			exp_q.push_back(exp);
			due_q.push_back(cycle + 2);
			name_q.push_back(test_name);
			// r0 never changes and r13 changes only through call
			if (link) begin
				model[cpu_pkg::link_reg] = value;
			end else if (rd != cpu_pkg::zero_reg && rd != cpu_pkg::link_reg) begin
				model[rd] = value;
			end
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
			instr = '0;
		end
	endtask

	task automatic load_imm(input cpu_pkg::reg_addr_t rd, input logic [7:0] imm);
		issue(instr_word(cpu_pkg::li, rd, imm[7:4], imm[3:0]));
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		test_name = "reset";
		repeat (4) begin
			@(negedge clk);
			if (result.valid !== 1'b0) begin
				$display("reset: result.valid is not low after reset");
				failures++;
			end
		end
		check_word("reset debug_out", 16'h0000, debug_out);
	endtask

	task automatic test_independent();
		test_name = "independent";
		for (int r = 1; r <= 6; r++) begin
			load_imm(4'(r), 8'($urandom));
		end
		// Shift amount 3 with bit 4 set
		load_imm(4'd10, 8'h13);
		idle(2);
		issue(instr_word(cpu_pkg::sub, 4'd7, 4'd0, 4'd1));
		idle(2);
		// add, sub, and, or, xor
		for (int c = 1; c <= 5; c++) begin
			issue(instr_word(4'(c), 4'd8, 4'd1, 4'd2));
			idle(2);
		end
		issue(instr_word(cpu_pkg::sll, 4'd9, 4'd1, 4'd10));
		idle(2);
		issue(instr_word(cpu_pkg::srl, 4'd9, 4'd3, 4'd10));
		idle(2);
		// r7 is negative
		issue(instr_word(cpu_pkg::slt, 4'd11, 4'd7, 4'd2));
		idle(2);
		issue(instr_word(cpu_pkg::slt, 4'd11, 4'd2, 4'd7));
		idle(2);
		issue(instr_word(cpu_pkg::addi, 4'd12, 4'd3, 4'd9));
		idle(2);
	endtask

	task automatic test_forwarding();
		logic [3:0] code;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		test_name = "forwarding";
		load_imm(4'd1, 8'h2c);
		issue(instr_word(cpu_pkg::add, 4'd2, 4'd1, 4'd1));
		issue(instr_word(cpu_pkg::sub, 4'd3, 4'd2, 4'd1));
		issue(instr_word(cpu_pkg::xor_op, 4'd1, 4'd3, 4'd2));
		issue(instr_word(cpu_pkg::addi, 4'd1, 4'd1, 4'd7));
		issue(instr_word(cpu_pkg::slt, 4'd4, 4'd3, 4'd1));
		idle(2);
		// Random dependent chain over a few registers
		repeat (24) begin
			code = 4'($urandom_range(11, 1));
			rd = 4'($urandom_range(6, 1));
			rs = 4'($urandom_range(6, 0));
			rt = 4'($urandom_range(6, 0));
			issue(instr_word(code, rd, rs, rt));
		end
		idle(3);
	endtask

	task automatic test_zero_reg();
		test_name = "zero_reg";
		load_imm(4'd0, 8'h5a);
		issue(instr_word(cpu_pkg::add, 4'd1, 4'd0, 4'd0));
		issue(instr_word(cpu_pkg::or_op, 4'd2, 4'd0, 4'd0));
		idle(2);
		issue(instr_word(cpu_pkg::add, 4'd3, 4'd0, 4'd0));
		idle(2);
	endtask

	task automatic test_link();
		test_name = "link";
		next_pc = 16'h0120;
		// call always targets r13 whatever the rd field
		issue(instr_word(cpu_pkg::call, 4'd3, 4'd0, 4'd0));
		issue(instr_word(cpu_pkg::add, 4'd3, 4'd13, 4'd0));
		issue(instr_word(cpu_pkg::add, 4'd4, 4'd0, 4'd13));
		idle(2);
		load_imm(4'd13, 8'h77);
		issue(instr_word(cpu_pkg::add, 4'd5, 4'd13, 4'd0));
		idle(2);
		issue(instr_word(cpu_pkg::add, 4'd6, 4'd0, 4'd13));
		idle(2);
	endtask

	task automatic test_debug();
		test_name = "debug";
		load_imm(4'd1, 8'($urandom));
		load_imm(4'd2, 8'($urandom));
		load_imm(4'd4, 8'($urandom));
		load_imm(4'd5, 8'($urandom));
		// Nops aimed at the debug registers
		issue(instr_word(cpu_pkg::nop, 4'd1, 4'd2, 4'd3));
		issue(instr_word(4'hc, 4'd2, 4'd1, 4'd1));
		issue(instr_word(4'hf, 4'd4, 4'd1, 4'd1));
		idle(4);
		@(negedge clk);
		check_word("debug", {model[1][3:0], model[2][3:0], model[4][3:0], model[5][3:0]},
			debug_out);
	endtask

	initial begin
		void'($urandom(32'h55ea4dc2));
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		foreach (model[i]) begin
			model[i] = '0;
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_independent();
		test_forwarding();
		test_zero_reg();
		test_link();
		test_debug();
		idle(4);
		if (exp_q.size() != 0) begin
			$display("%0d expected results never appeared", exp_q.size());
			failures++;
		end
		$display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog timeout: tests did not finish within %0d ns", watchdog_ns);
		$display("TB FAILED");
		$finish;
	end

endmodule
